//--- verif/bd_perf_model.svh
// Expected statistics, kept in the types the DUT reports
chan_counts_t exp_counts;
stat_t        exp_lat;
stat_t        exp_skew;
int           rq_cycle;
logic         rq_open;
int           in_cycle [CT_INPUTS];

task automatic clear_model();
  exp_counts = '0;
  exp_lat    = '0;
  exp_skew   = '0;
  rq_open    = 1'b0;
endtask

// Running sum, largest sample and number of samples
function automatic stat_t add_sample(input stat_t s, input int unsigned v);
  stat_t r;
  r = s;
  r.total = s.total + STAT_W'(v);
  if (STAT_W'(v) > s.max) begin
    r.max = STAT_W'(v);
  end
  r.count = s.count + STAT_W'(1);
  return r;
endfunction

// Wire index 0 to 3 is L.q, L.a, R.q, R.a
task automatic note_chan_toggle(input int w);
  case (w)
    0: exp_counts.n_lq = exp_counts.n_lq + STAT_W'(1);
    1: exp_counts.n_la = exp_counts.n_la + STAT_W'(1);
    2: begin
      exp_counts.n_rq = exp_counts.n_rq + STAT_W'(1);
      rq_cycle = cycle;
      rq_open  = 1'b1;
    end
    default: begin
      exp_counts.n_ra = exp_counts.n_ra + STAT_W'(1);
      // Latency is the drive-cycle gap from the open request
      if (rq_open) begin
        exp_lat = add_sample(exp_lat, cycle - rq_cycle);
      end
      rq_open = 1'b0;
    end
  endcase
endtask

task automatic note_input(input int i);
  in_cycle[i] = cycle;
endtask

// Skew is the spread of the input drive cycles of this event
task automatic note_output();
  int latest;
  int earliest;
  latest   = in_cycle[0];
  earliest = in_cycle[0];
  for (int i = 1; i < CT_INPUTS; i++) begin
    if (in_cycle[i] > latest) begin
      latest = in_cycle[i];
    end
    if (in_cycle[i] < earliest) begin
      earliest = in_cycle[i];
    end
  end
  exp_skew = add_sample(exp_skew, latest - earliest);
endtask

function automatic logic [STAT_W-1:0] expected_word(input stat_sel_e sel);
  case (sel)
    SEL_N_LQ:       return exp_counts.n_lq;
    SEL_N_LA:       return exp_counts.n_la;
    SEL_N_RQ:       return exp_counts.n_rq;
    SEL_N_RA:       return exp_counts.n_ra;
    SEL_LAT_TOTAL:  return exp_lat.total;
    SEL_LAT_MAX:    return exp_lat.max;
    SEL_LAT_COUNT:  return exp_lat.count;
    SEL_SKEW_TOTAL: return exp_skew.total;
    SEL_SKEW_MAX:   return exp_skew.max;
    default:        return exp_skew.count;
  endcase
endfunction

function automatic chan_idle_t idle_flags(input logic l, input logic r, input logic ct);
  chan_idle_t f;
  f.l_idle  = l;
  f.r_idle  = r;
  f.ct_idle = ct;
  return f;
endfunction

//--- verif/bd_perf_mon_tb.sv
module bd_perf_mon_tb;
  import bd_perf_pkg::*;

  localparam int CT_INPUTS  = 3;
  localparam int HANDSHAKES = 200;
  localparam int CT_EVENTS  = 100;
  // Cycle budget per handshake and per C-element event, plus the fixed phases
  localparam int CYCLE_LIMIT = HANDSHAKES * 10 + CT_EVENTS * 30 + 500;

  logic                 CLK;
  logic                 reset;
  logic                 l_q;
  logic                 l_a;
  logic                 r_q;
  logic                 r_a;
  logic [CT_INPUTS-1:0] ct_a;
  logic                 ct_x;
  stat_sel_e            stat_sel;
  logic                 stat_rd;
  logic [STAT_W-1:0]    stat_data;
  logic                 stat_valid;
  chan_idle_t           idle;

  int                   cycle;
  int                   checks;
  int unsigned          seed_ret;

  `include "bd_perf_model.svh"

  bd_perf_mon_top #(.CT_INPUTS(CT_INPUTS)) dut0 (.*);

  always #10 CLK = ~CLK;

  // Cycle count serves as drive stamp and as run limit
  always @(posedge CLK) begin
    cycle <= cycle + 1;
    if (cycle > CYCLE_LIMIT) begin
      abort_run($sformatf("Timeout: the run went past %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_stat(input stat_sel_e sel, input logic [STAT_W-1:0] got,
                            input logic [STAT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: %s read 0x%0h, expected 0x%0h",
                          $time, sel.name(), got, exp));
    end
  endtask

  task automatic check_idle(input chan_idle_t got, input chan_idle_t exp);
    checks++;
    if (got !== exp) begin
      abort_run($sformatf("ERROR at %0t: idle flags l/r/ct %b, expected %b",
                          $time, got, exp));
    end
  endtask

  // Inputs change 1 unit after the rising edge
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic read_stat(input stat_sel_e sel, output logic [STAT_W-1:0] data);
    stat_sel = sel;
    stat_rd  = 1'b1;
    if (stat_valid !== 1'b0) begin
      abort_run("stat_valid was already high when the read strobe started");
    end
    step();
    stat_rd = 1'b0;
    if (stat_valid !== 1'b1) begin
      abort_run("stat_valid did not rise one cycle after stat_rd");
    end
    data = stat_data;
    step();
    if (stat_valid !== 1'b0 || stat_data !== data) begin
      abort_run("stat_valid stayed high or stat_data changed without a read");
    end
  endtask

  task automatic check_all_stats();
    logic [STAT_W-1:0] d;
    for (int s = 0; s <= int'(SEL_SKEW_COUNT); s++) begin
      read_stat(stat_sel_e'(s), d);
      check_stat(stat_sel_e'(s), d, expected_word(stat_sel_e'(s)));
    end
  endtask

  task automatic run_handshake();
    int lat_gap;
    int rest_gap;
    lat_gap  = $urandom_range(1, 8);
    rest_gap = $urandom_range(1, 8);
    step();
    l_q = ~l_q;
    note_chan_toggle(0);
    step();
    r_q = ~r_q;
    note_chan_toggle(2);
    repeat (lat_gap) step();
    r_a = ~r_a;
    note_chan_toggle(3);
    step();
    l_a = ~l_a;
    note_chan_toggle(1);
    repeat (rest_gap) step();
  endtask

  // Every input toggles once in shuffled order, then the output
  task automatic run_celem_event();
    int order [CT_INPUTS];
    int j;
    int tmp;
    for (int i = 0; i < CT_INPUTS; i++) begin
      order[i] = i;
    end
    for (int i = CT_INPUTS - 1; i > 0; i--) begin
      j        = $urandom_range(0, i);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    step();
    for (int i = 0; i < CT_INPUTS; i++) begin
      repeat ($urandom_range(0, 2)) step();
      ct_a[order[i]] = ~ct_a[order[i]];
      note_input(order[i]);
    end
    repeat ($urandom_range(1, 2)) step();
    ct_x = ~ct_x;
    note_output();
    repeat (2) step();
  endtask

  initial begin
    seed_ret = $urandom(32'h2ea6f509);
    CLK      = 1'b0;
    reset    = 1'b1;
    cycle    = 0;
    checks   = 0;
    l_a      = 1'b0;
    r_q      = 1'b0;
    ct_a     = '0;
    ct_x     = 1'b0;
    stat_sel = SEL_N_LQ;
    stat_rd  = 1'b0;
    // Random initial tokens on L and R
    l_q      = $urandom_range(0, 1);
    r_a      = $urandom_range(0, 1);
    clear_model();
    repeat (2) step();
    reset = 1'b0;
    repeat (5) step();
    check_idle(idle, idle_flags(1'b1, 1'b1, 1'b1));
    check_stat(SEL_N_LQ, stat_data, '0);

    // Request in on L with no acknowledge yet
    l_q = ~l_q;
    note_chan_toggle(0);
    repeat (4) step();
    check_idle(idle, idle_flags(1'b0, 1'b1, 1'b1));
    l_a = ~l_a;
    note_chan_toggle(1);
    repeat (4) step();
    check_idle(idle, idle_flags(1'b1, 1'b1, 1'b1));

    // Request out with no acknowledge yet
    r_q = ~r_q;
    note_chan_toggle(2);
    repeat (4) step();
    check_idle(idle, idle_flags(1'b1, 1'b0, 1'b1));
    r_a = ~r_a;
    note_chan_toggle(3);
    repeat (4) step();
    check_idle(idle, idle_flags(1'b1, 1'b1, 1'b1));
    // One C-element input ahead of the others
    ct_a[0] = ~ct_a[0];
    note_input(0);
    repeat (4) step();
    check_idle(idle, idle_flags(1'b1, 1'b1, 1'b0));
    for (int i = 1; i < CT_INPUTS; i++) begin
      ct_a[i] = ~ct_a[i];
      note_input(i);
    end
    step();
    ct_x = ~ct_x;
    note_output();
    repeat (4) step();
    check_idle(idle, idle_flags(1'b1, 1'b1, 1'b1));

    repeat (HANDSHAKES) run_handshake();
    repeat (CT_EVENTS) run_celem_event();
    repeat (5) step();
    check_all_stats();

    // Second reset clears every statistic
    reset = 1'b1;
    repeat (2) step();
    reset = 1'b0;
    clear_model();
    repeat (5) step();
    check_all_stats();

    if (checks > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run("No checks were run");
    end
  end

endmodule

//--- verilog.f
+incdir+verif
verilog/bd_perf_pkg.sv
verilog/toggle_sync.sv
verilog/channel_monitor.sv
verilog/celem_skew_meter.sv
verilog/perf_readout.sv
verilog/bd_perf_mon_top.sv
verif/bd_perf_mon_tb.sv

//--- verilog/bd_perf_mon_top.sv
module bd_perf_mon_top #(
  parameter int CT_INPUTS = 3
) (
  input  logic                           CLK,
  input  logic                           reset,
  input  logic                           l_q,
  input  logic                           l_a,
  input  logic                           r_q,
  input  logic                           r_a,
  input  logic [CT_INPUTS-1:0]           ct_a,
  input  logic                           ct_x,
  input  bd_perf_pkg::stat_sel_e         stat_sel,
  input  logic                           stat_rd,
  output logic [bd_perf_pkg::STAT_W-1:0] stat_data,
  output logic                           stat_valid,
  output bd_perf_pkg::chan_idle_t        idle
);
  import bd_perf_pkg::*;

  chan_sample_t         chan_level;
  chan_sample_t         chan_toggle;
  logic [CT_INPUTS-1:0] ct_level;
  logic [CT_INPUTS-1:0] ct_toggle;
  logic                 x_toggle;
  chan_counts_t         counts;
  stat_t                lat;
  stat_t                skew;

  // Bit order follows chan_sample_t, lq in the top bit
  toggle_sync #(.SYNC_W(4)) chan_sync (
    .CLK(CLK), .reset(reset), .async_in({l_q, l_a, r_q, r_a}),
    .level(chan_level), .toggle(chan_toggle)
  );

  toggle_sync #(.SYNC_W(CT_INPUTS)) ct_sync (
    .CLK(CLK), .reset(reset), .async_in(ct_a),
    .level(ct_level), .toggle(ct_toggle)
  );

  // Only the edges of the C-element output are of interest
  toggle_sync #(.SYNC_W(1)) x_sync (
    .CLK(CLK), .reset(reset), .async_in(ct_x),
    .level(), .toggle(x_toggle)
  );

  channel_monitor chan_mon (
    .CLK(CLK), .reset(reset), .level(chan_level), .toggle(chan_toggle),
    .l_idle(idle.l_idle), .r_idle(idle.r_idle), .counts(counts), .lat(lat)
  );

  celem_skew_meter #(.CT_INPUTS(CT_INPUTS)) ct_mon (
    .CLK(CLK), .reset(reset), .level(ct_level), .toggle(ct_toggle),
    .x_toggle(x_toggle), .ct_idle(idle.ct_idle), .skew(skew)
  );

  perf_readout readout (
    .CLK(CLK), .reset(reset), .stat_sel(stat_sel), .stat_rd(stat_rd),
    .counts(counts), .lat(lat), .skew(skew),
    .stat_data(stat_data), .stat_valid(stat_valid)
  );

endmodule

//--- verilog/bd_perf_pkg.sv
package bd_perf_pkg;

  // Width of every statistic and of the read data
  localparam int STAT_W = 32;

  // Controller wires, as levels or as toggle pulses
  typedef struct packed {
    logic lq;
    logic la;
    logic rq;
    logic ra;
  } chan_sample_t;

  typedef struct packed {
    logic l_idle;
    logic r_idle;
    logic ct_idle;
  } chan_idle_t;

  // One latency or skew statistic
  typedef struct packed {
    logic [STAT_W-1:0] total;
    logic [STAT_W-1:0] max;
    logic [STAT_W-1:0] count;
  } stat_t;

  typedef struct packed {
    logic [STAT_W-1:0] n_lq;
    logic [STAT_W-1:0] n_la;
    logic [STAT_W-1:0] n_rq;
    logic [STAT_W-1:0] n_ra;
  } chan_counts_t;

  typedef enum logic [3:0] {
    SEL_N_LQ       = 4'd0,
    SEL_N_LA       = 4'd1,
    SEL_N_RQ       = 4'd2,
    SEL_N_RA       = 4'd3,
    SEL_LAT_TOTAL  = 4'd4,
    SEL_LAT_MAX    = 4'd5,
    SEL_LAT_COUNT  = 4'd6,
    SEL_SKEW_TOTAL = 4'd7,
    SEL_SKEW_MAX   = 4'd8,
    SEL_SKEW_COUNT = 4'd9
  } stat_sel_e;

  // Add that sticks at all ones instead of wrapping
  function automatic logic [STAT_W-1:0] sat_add(input logic [STAT_W-1:0] a,
                                                input logic [STAT_W-1:0] b);
    logic [STAT_W:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[STAT_W] ? '1 : sum[STAT_W-1:0];
  endfunction

  // Fold one new sample into a statistic
  function automatic stat_t stat_update(input stat_t s, input logic [STAT_W-1:0] sample);
    stat_t r;
    r.total = sat_add(s.total, sample);
    r.max   = (sample > s.max) ? sample : s.max;
    r.count = sat_add(s.count, STAT_W'(1));
    return r;
  endfunction

endpackage

//--- verilog/celem_skew_meter.sv
module celem_skew_meter #(
  parameter int CT_INPUTS = 3
) (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic [CT_INPUTS-1:0] level,
  input  logic [CT_INPUTS-1:0] toggle,
  input  logic                 x_toggle,
  output logic                 ct_idle,
  output bd_perf_pkg::stat_t   skew
);
  import bd_perf_pkg::*;

  logic [1:0]        start_cnt;
  logic              armed;
  logic [STAT_W-1:0] cyc;
  logic [STAT_W-1:0] stamp [CT_INPUTS];
  logic [STAT_W-1:0] latest;
  logic [STAT_W-1:0] earliest;

  // Skip the synchronizer edges that follow reset
  assign armed = (start_cnt == 2'd3);

  always_ff @(posedge CLK) begin
    if (reset) begin
      start_cnt <= '0;
      cyc       <= '0;
    end else begin
      if (!armed) begin
        start_cnt <= start_cnt + 2'd1;
      end
      cyc <= cyc + STAT_W'(1);
    end
  end

  // Last toggle cycle of each input
  always_ff @(posedge CLK) begin
    for (int i = 0; i < CT_INPUTS; i++) begin
      if (toggle[i]) begin
        stamp[i] <= cyc;
      end
    end
  end

  // An input toggling in this very cycle uses the current stamp
  always_comb begin
    logic [STAT_W-1:0] eff;
    latest   = '0;
    earliest = '1;
    for (int i = 0; i < CT_INPUTS; i++) begin
      eff = toggle[i] ? cyc : stamp[i];
      if (eff > latest) begin
        latest = eff;
      end
      if (eff < earliest) begin
        earliest = eff;
      end
    end
  end

  // All inputs at the same level
  assign ct_idle = (&level) | ~(|level);

  always_ff @(posedge CLK) begin
    if (reset) begin
      skew <= '0;
    end else if (armed && x_toggle) begin
      skew <= stat_update(skew, latest - earliest);
    end
  end

  // The C-element only fires once its inputs have all arrived
  a_x_agree: assert property (@(posedge CLK) disable iff (reset)
    (armed && x_toggle) |-> ct_idle);

endmodule

//--- verilog/channel_monitor.sv
module channel_monitor (
  input  logic                      CLK,
  input  logic                      reset,
  input  bd_perf_pkg::chan_sample_t level,
  input  bd_perf_pkg::chan_sample_t toggle,
  output logic                      l_idle,
  output logic                      r_idle,
  output bd_perf_pkg::chan_counts_t counts,
  output bd_perf_pkg::stat_t        lat
);
  import bd_perf_pkg::*;

  logic [1:0]        start_cnt;
  logic              armed;
  logic              l_inv;
  logic              r_inv;
  logic [STAT_W-1:0] cyc;
  logic [STAT_W-1:0] rq_stamp;
  logic              rq_pending;

  // Toggles from the synchronizer leaving reset are ignored until armed
  assign armed = (start_cnt == 2'd3);

  always_ff @(posedge CLK) begin
    if (reset) begin
      start_cnt <= '0;
      l_inv     <= 1'b0;
      r_inv     <= 1'b0;
    end else begin
      if (!armed) begin
        start_cnt <= start_cnt + 2'd1;
      end
      // An initial token leaves the channel inverted
      if (start_cnt == 2'd2) begin
        l_inv <= level.lq;
        r_inv <= level.ra;
      end
    end
  end

  // Idle when request and acknowledge are back in phase
  assign l_idle = ((level.lq ^ l_inv) == level.la);
  assign r_idle = (level.rq == (level.ra ^ r_inv));

  always_ff @(posedge CLK) begin
    if (reset) begin
      counts <= '0;
    end else if (armed) begin
      if (toggle.lq) begin
        counts.n_lq <= sat_add(counts.n_lq, STAT_W'(1));
      end
      if (toggle.la) begin
        counts.n_la <= sat_add(counts.n_la, STAT_W'(1));
      end
      if (toggle.rq) begin
        counts.n_rq <= sat_add(counts.n_rq, STAT_W'(1));
      end
      if (toggle.ra) begin
        counts.n_ra <= sat_add(counts.n_ra, STAT_W'(1));
      end
    end
  end

  // Free-running cycle stamp
  always_ff @(posedge CLK) begin
    if (reset) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + STAT_W'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (toggle.rq) begin
      rq_stamp <= cyc;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      rq_pending <= 1'b0;
      lat        <= '0;
    end else if (armed) begin
      // R.a closes the request opened by the last R.q
      if (toggle.ra && rq_pending) begin
        lat <= stat_update(lat, cyc - rq_stamp);
      end
      if (toggle.rq) begin
        rq_pending <= 1'b1;
      end else if (toggle.ra) begin
        rq_pending <= 1'b0;
      end
    end
  end

  a_lat_count: assert property (@(posedge CLK) disable iff (reset)
    lat.count <= counts.n_ra);

  a_lat_max: assert property (@(posedge CLK) disable iff (reset)
    lat.max <= lat.total);

endmodule

//--- verilog/perf_readout.sv
module perf_readout (
  input  logic                      CLK,
  input  logic                      reset,
  input  bd_perf_pkg::stat_sel_e    stat_sel,
  input  logic                      stat_rd,
  input  bd_perf_pkg::chan_counts_t counts,
  input  bd_perf_pkg::stat_t        lat,
  input  bd_perf_pkg::stat_t        skew,
  output logic [bd_perf_pkg::STAT_W-1:0] stat_data,
  output logic                      stat_valid
);
  import bd_perf_pkg::*;

  logic [STAT_W-1:0] word;

  always_comb begin
    case (stat_sel)
      SEL_N_LQ:       word = counts.n_lq;
      SEL_N_LA:       word = counts.n_la;
      SEL_N_RQ:       word = counts.n_rq;
      SEL_N_RA:       word = counts.n_ra;
      SEL_LAT_TOTAL:  word = lat.total;
      SEL_LAT_MAX:    word = lat.max;
      SEL_LAT_COUNT:  word = lat.count;
      SEL_SKEW_TOTAL: word = skew.total;
      SEL_SKEW_MAX:   word = skew.max;
      SEL_SKEW_COUNT: word = skew.count;
      default:        word = '0;
    endcase
  end

  // Data is held until the next read strobe
  always_ff @(posedge CLK) begin
    if (reset) begin
      stat_valid <= 1'b0;
      stat_data  <= '0;
    end else begin
      stat_valid <= stat_rd;
      if (stat_rd) begin
        stat_data <= word;
      end
    end
  end

  a_sel_legal: assert property (@(posedge CLK) disable iff (reset)
    stat_rd |-> stat_sel inside {SEL_N_LQ, SEL_N_LA, SEL_N_RQ, SEL_N_RA,
                                 SEL_LAT_TOTAL, SEL_LAT_MAX, SEL_LAT_COUNT,
                                 SEL_SKEW_TOTAL, SEL_SKEW_MAX, SEL_SKEW_COUNT});

endmodule

//--- verilog/toggle_sync.sv
module toggle_sync #(
  parameter int SYNC_W = 1
) (
  input  logic              CLK,
  input  logic              reset,
  input  logic [SYNC_W-1:0] async_in,
  output logic [SYNC_W-1:0] level,
  output logic [SYNC_W-1:0] toggle
);

  // First stage may go metastable, second is the usable level
  logic [SYNC_W-1:0] meta;
  logic [SYNC_W-1:0] sync;
  // Previous synchronized sample, for edge detection
  logic [SYNC_W-1:0] prev;

  always_ff @(posedge CLK) begin
    if (reset) begin
      meta <= '0;
      sync <= '0;
      prev <= '0;
    end else begin
      meta <= async_in;
      sync <= meta;
      prev <= sync;
    end
  end

  assign level = sync;

  // High for the one cycle in which the level differs from its last value
  assign toggle = sync ^ prev;

endmodule
